// File: list.f
source/cache_pkg.sv
source/cache_array.sv
source/cache_fill_fsm.sv
source/cache.sv
source/main_memory.sv
source/cache_subsystem.sv
verif/tb_cache_subsystem.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_cache_subsystem
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "TEST RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verif/tb_cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cache_subsystem;
	import cache_pkg::*;

	localparam int CLK_PERIOD      = 100;
	localparam int DRIVE_DLY       = 5; // after the rising edge
	localparam int RESET_CYCLES    = 4;
	localparam int NUM_ROWS        = 18;
	localparam int WAIT_LIMIT      = 4 * FILL_CYCLES;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * FILL_CYCLES + 20;

	localparam logic              WR     = 1'b1;
	localparam logic              RD     = 1'b0;
	localparam logic [ADDR_W-1:0] LINE_A = 16'h0850; // tag 1, index 5
	localparam logic [ADDR_W-1:0] LINE_B = 16'h1050; // tag 2, same index as A
	localparam logic [ADDR_W-1:0] LINE_C = 16'h1890; // tag 3, index 9

	typedef struct packed {
		logic              is_write;
		logic [ADDR_W-1:0] addr;
		word_t             wdata;
		logic              exp_miss;
		word_t             exp_data;
	} row_t;

	logic              clk;
	logic              rst_n;
	logic              mem_read;
	logic [ADDR_W-1:0] read_addr;
	logic              mem_write;
	logic [ADDR_W-1:0] write_addr;
	word_t             write_data;
	word_t             data_out;
	logic              hit;
	logic              miss;
	logic              busy;
	logic              done;

	row_t             rows [$];
	word_t            ref_mem [MEM_WORDS]; // last word written per address
	logic             ref_written [MEM_WORDS];
	logic             tag_valid [SETS];
	logic [TAG_W-1:0] tag_value [SETS];
	logic [31:0]      lfsr_state;

	cache_subsystem u_cache_subsystem (
		.clk       (clk),
		.rst_n     (rst_n),
		.mem_read  (mem_read),
		.read_addr (read_addr),
		.mem_write (mem_write),
		.write_addr(write_addr),
		.write_data(write_data),
		.data_out  (data_out),
		.hit       (hit),
		.miss      (miss),
		.busy      (busy),
		.done      (done)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got 0x%0h expected 0x%0h",
				$time, name, got, exp);
			$display("TEST RESULT: FAIL");
			$fatal(1, "stopping at first mismatch");
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic draw_word(output word_t w);
		for (int i = 0; i < DATA_W; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			w[i] = lfsr_state[0]; // one step per bit
		end
	endtask

	task automatic clear_model();
		for (int i = 0; i < MEM_WORDS; i++) begin
			ref_mem[i] = '0;
			ref_written[i] = 1'b0;
		end
		for (int i = 0; i < SETS; i++) begin
			tag_valid[i] = 1'b0;
			tag_value[i] = '0;
		end
	endtask

	// expected values come from the tag table and reference memory
	task automatic add_row(input logic is_write, input logic [ADDR_W-1:0] addr);
		row_t              r;
		word_t             w;
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0]   tg;
		logic [ADDR_W-2:0]  waddr;
		idx = addr[WORD_W+1 +: INDEX_W];
		tg = addr[ADDR_W-1 -: TAG_W];
		waddr = addr[ADDR_W-1:1];
		r.is_write = is_write;
		r.addr = addr;
		r.wdata = '0;
		r.exp_data = '0;
		r.exp_miss = !(tag_valid[idx] && (tag_value[idx] == tg));
		tag_valid[idx] = 1'b1; // reads and writes both allocate
		tag_value[idx] = tg;
		if (is_write) begin
			draw_word(w);
			r.wdata = w;
			ref_mem[waddr] = w;
			ref_written[waddr] = 1'b1;
		end else if (ref_written[waddr]) begin
			r.exp_data = ref_mem[waddr];
		end else begin
			$display("stimulus table reads address 0x%04h before any write to it", addr);
			$display("TEST RESULT: FAIL");
			$fatal(1, "bad stimulus table");
		end
		rows.push_back(r);
	endtask

	task automatic build_table();
		add_row(WR, LINE_A);          // first access after reset misses
		add_row(RD, LINE_A);
		add_row(WR, LINE_A + 16'd6);  // write hit, resident line
		add_row(WR, LINE_C);
		add_row(RD, LINE_C);
		add_row(WR, LINE_B + 16'd4);  // evicts A
		add_row(RD, LINE_B + 16'd4);
		add_row(RD, LINE_A + 16'd6);  // back from memory
		add_row(RD, LINE_A);
		add_row(WR, LINE_A);          // new word on a resident line
		add_row(RD, LINE_A);
		add_row(RD, LINE_A + 16'd6);
		add_row(RD, LINE_B + 16'd4);
		add_row(RD, LINE_C);
		add_row(WR, LINE_A + 16'd14);
		add_row(RD, LINE_A);
		add_row(RD, LINE_A + 16'd14);
		add_row(RD, LINE_A + 16'd6);
		if (rows.size() != NUM_ROWS) begin
			$display("stimulus table holds %0d rows instead of %0d", rows.size(), NUM_ROWS);
			$display("TEST RESULT: FAIL");
			$fatal(1, "bad stimulus table");
		end
	endtask

	task automatic apply_row(input row_t r);
		int edges;
		int done_cycles;
		@(posedge clk);
		#DRIVE_DLY;
		mem_read = !r.is_write;
		mem_write = r.is_write;
		read_addr = r.addr;
		write_addr = r.addr;
		write_data = r.wdata;
		@(negedge clk); // first cycle of the request
		check_equal("miss", 32'(miss), 32'(r.exp_miss));
		check_equal("hit", 32'(hit), 32'(!r.exp_miss));
		check_equal("busy", 32'(busy), 32'd0);
		check_equal("done", 32'(done), 32'd0);
		if (r.exp_miss) begin
			edges = 0;
			done_cycles = 0;
			while (!hit && edges < WAIT_LIMIT) begin
				@(posedge clk);
				edges++;
				@(negedge clk);
				if (done) begin
					done_cycles++;
				end
				if (!hit) begin
					check_equal("busy", 32'(busy), 32'd1); // fill in progress
				end
			end
			check_equal("hit", 32'(hit), 32'd1);
			check_equal("fill edges", edges, FILL_CYCLES);
			check_equal("done pulses", done_cycles, 32'd1);
			check_equal("busy", 32'(busy), 32'd0);
		end
		if (!r.is_write) begin
			check_equal("data_out", 32'(data_out), 32'(r.exp_data));
		end
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("run hung: no end after %0d clock periods", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		mem_read = 1'b0;
		read_addr = '0;
		mem_write = 1'b0;
		write_addr = '0;
		write_data = '0;
		lfsr_state = 32'h25eb_cb5b;
		clear_model();
		build_table();
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		rst_n = 1'b1;
		@(negedge clk); // idle, no request
		check_equal("busy", 32'(busy), 32'd0);
		check_equal("done", 32'(done), 32'd0);
		check_equal("miss", 32'(miss), 32'd0);
		check_equal("hit", 32'(hit), 32'd0);
		foreach (rows[i]) begin
			apply_row(rows[i]);
		end
		@(posedge clk); // completes the last request
		#DRIVE_DLY;
		mem_read = 1'b0;
		mem_write = 1'b0;
		@(negedge clk);
		check_equal("busy", 32'(busy), 32'd0);
		check_equal("done", 32'(done), 32'd0);
		$display("applied %0d table rows", rows.size());
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: source/cache_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

module cache_subsystem (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         mem_read,
	input  logic [cache_pkg::ADDR_W-1:0] read_addr,
	input  logic                         mem_write,
	input  logic [cache_pkg::ADDR_W-1:0] write_addr,
	input  cache_pkg::word_t             write_data,
	output cache_pkg::word_t             data_out,
	output logic                         hit,
	output logic                         miss,
	output logic                         busy,
	output logic                         done
);
	import cache_pkg::*;

	logic              mem_rd;
	logic              mem_wr;
	logic [ADDR_W-1:0] mem_addr;
	word_t             mem_wdata;
	word_t             mem_rdata;
	logic              mem_valid;

	cache u_cache (
		.clk            (clk),
		.rst_n          (rst_n),
		.mem_read       (mem_read),
		.read_addr      (read_addr),
		.mem_write      (mem_write),
		.write_addr     (write_addr),
		.write_data     (write_data),
		.mem_rdata      (mem_rdata),
		.mem_valid      (mem_valid),
		.data_out       (data_out),
		.hit            (hit),
		.miss           (miss),
		.busy           (busy),
		.done           (done),
		.cache_mem_read (mem_rd),
		.cache_mem_write(mem_wr),
		.cache_mem_addr (mem_addr),
		.cache_mem_wdata(mem_wdata)
	);

	main_memory u_mem (
		.clk      (clk),
		.rst_n    (rst_n),
		.mem_read (mem_rd),
		.mem_write(mem_wr),
		.mem_addr (mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata),
		.mem_valid(mem_valid)
	);

endmodule

`default_nettype wire

// File: source/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

module main_memory (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         mem_read,
	input  logic                         mem_write,
	input  logic [cache_pkg::ADDR_W-1:0] mem_addr,
	input  cache_pkg::word_t             mem_wdata,
	output cache_pkg::word_t             mem_rdata,
	output logic                         mem_valid
);
	import cache_pkg::*;

	localparam int WADDR_W = $clog2(MEM_WORDS);

	word_t                mem [MEM_WORDS];
	logic [WADDR_W-1:0]   word_addr;
	logic [MEM_LATENCY-1:0] valid_pipe;
	word_t                data_pipe [MEM_LATENCY];

	assign word_addr = mem_addr[ADDR_W-1:1]; // drop byte bit

	always_ff @(posedge clk) begin
		if (mem_write) begin
			mem[word_addr] <= mem_wdata;
		end
	end

	// valid travels alongside the data, one stage per cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_pipe <= '0;
		end else begin
			valid_pipe <= {valid_pipe[MEM_LATENCY-2:0], mem_read};
		end
	end

	always_ff @(posedge clk) begin
		data_pipe[0] <= mem[word_addr]; // sampled with the request
		for (int i = 1; i < MEM_LATENCY; i++) begin
			data_pipe[i] <= data_pipe[i-1];
		end
	end

	assign mem_valid = valid_pipe[MEM_LATENCY-1];
	assign mem_rdata = data_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

// File: source/cache.sv
`timescale 1ns/1ps
`default_nettype none

module cache (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         mem_read,
	input  logic [cache_pkg::ADDR_W-1:0] read_addr,
	input  logic                         mem_write,
	input  logic [cache_pkg::ADDR_W-1:0] write_addr,
	input  cache_pkg::word_t             write_data,
	input  cache_pkg::word_t             mem_rdata,
	input  logic                         mem_valid,
	output cache_pkg::word_t             data_out,
	output logic                         hit,
	output logic                         miss,
	output logic                         busy,
	output logic                         done,
	output logic                         cache_mem_read,
	output logic                         cache_mem_write,
	output logic [cache_pkg::ADDR_W-1:0] cache_mem_addr,
	output cache_pkg::word_t             cache_mem_wdata
);
	import cache_pkg::*;

	logic [ADDR_W-1:0]  addr;
	logic [TAG_W-1:0]   tag;
	logic [INDEX_W-1:0] index;
	logic [WORD_W-1:0]  word;

	logic               fill_write;
	logic [WORD_W-1:0]  fill_offset;
	logic [ADDR_W-1:0]  fill_base;
	logic [ADDR_W-1:0]  fill_read_addr;
	logic               tag_write;

	tag_entry_t         tag_rd;
	tag_entry_t         tag_wr;
	logic               data_we;
	logic [WORD_W-1:0]  data_word;
	word_t              data_wr;

	cache_fill_fsm u_fill (
		.clk          (clk),
		.rst_n        (rst_n),
		.miss         (miss),
		.miss_addr    (addr),
		.mem_valid    (mem_valid),
		.busy         (busy),
		.mem_read     (cache_mem_read),
		.mem_read_addr(fill_read_addr),
		.write_data   (fill_write),
		.write_offset (fill_offset),
		.base_addr    (fill_base),
		.write_tag    (tag_write)
	);

	// fill beats write, write beats read
	assign addr = fill_write ? fill_base :
		mem_write ? write_addr : read_addr;

	assign tag   = addr[ADDR_W-1 -: TAG_W];
	assign index = addr[WORD_W+1 +: INDEX_W];
	assign word  = addr[1 +: WORD_W]; // bit 0 is the byte bit

	assign tag_wr.valid = 1'b1;
	assign tag_wr.tag   = tag;

	cache_array #(
		.entry_t(tag_entry_t),
		.WORDS  (1)
	) u_tags (
		.clk  (clk),
		.rst_n(rst_n),
		.index(index),
		.word (word),
		.write(tag_write),
		.wdata(tag_wr),
		.rdata(tag_rd)
	);

	assign hit  = (mem_read || mem_write) && tag_rd.valid && (tag_rd.tag == tag);
	assign miss = (mem_read || mem_write) && !hit;

	// fill words come from memory, a write hit from the pipeline
	assign data_we   = fill_write || (mem_write && hit);
	assign data_word = fill_write ? fill_offset : word;
	assign data_wr   = fill_write ? mem_rdata : write_data;

	cache_array #(
		.entry_t(word_t),
		.WORDS  (LINE_WORDS)
	) u_data (
		.clk  (clk),
		.rst_n(rst_n),
		.index(index),
		.word (data_word),
		.write(data_we),
		.wdata(data_wr),
		.rdata(data_out)
	);

	// write-through, held off while a fill owns the memory
	assign cache_mem_write = mem_write && !busy;
	assign cache_mem_wdata = write_data;
	assign cache_mem_addr  = cache_mem_read ? fill_read_addr :
		cache_mem_write ? write_addr : read_addr;

	// one-cycle pulse after the tag write
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			done <= 1'b0;
		end else begin
			done <= tag_write;
		end
	end

endmodule

`default_nettype wire

// File: source/cache_fill_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module cache_fill_fsm (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         miss,
	input  logic [cache_pkg::ADDR_W-1:0] miss_addr,
	input  logic                         mem_valid,
	output logic                         busy,
	output logic                         mem_read,
	output logic [cache_pkg::ADDR_W-1:0] mem_read_addr,
	output logic                         write_data,
	output logic [cache_pkg::WORD_W-1:0] write_offset,
	output logic [cache_pkg::ADDR_W-1:0] base_addr,
	output logic                         write_tag
);
	import cache_pkg::*;

	localparam int LINE_LSB = WORD_W + 1; // word bits plus byte bit

	typedef enum logic {
		IDLE,
		FILL
	} state_t;

	state_t            state;
	logic [WORD_W-1:0] issue_cnt;  // next word to request
	logic [WORD_W-1:0] return_cnt; // next word to come back
	logic              start;
	logic              last_issue;
	logic              last_return;

	assign start       = (state == IDLE) && miss;
	assign busy        = (state == FILL);
	assign last_issue  = mem_read && (issue_cnt == WORD_W'(LINE_WORDS - 1));
	assign last_return = write_data && (return_cnt == WORD_W'(LINE_WORDS - 1));

	assign write_data    = busy && mem_valid; // every returned word goes to the data array
	assign write_offset  = return_cnt;
	assign write_tag     = last_return; // tag lands with the final word
	assign mem_read_addr = {base_addr[ADDR_W-1:LINE_LSB], issue_cnt, 1'b0};

	// reads go out back to back, returns are counted on their own
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			mem_read   <= 1'b0;
			issue_cnt  <= '0;
			return_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (start) begin
						state      <= FILL;
						mem_read   <= 1'b1;
						issue_cnt  <= '0;
						return_cnt <= '0;
					end
				end
				FILL: begin
					if (mem_read) begin
						issue_cnt <= issue_cnt + 1'b1;
					end
					if (last_issue) begin
						mem_read <= 1'b0; // all eight requests out
					end
					if (write_data) begin
						return_cnt <= return_cnt + 1'b1;
					end
					if (last_return) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// line base of the missing address, held for the whole fill
	always_ff @(posedge clk) begin
		if (start) begin
			base_addr <= {miss_addr[ADDR_W-1:LINE_LSB], {LINE_LSB{1'b0}}};
		end
	end

endmodule

`default_nettype wire

// File: source/cache_array.sv
`timescale 1ns/1ps
`default_nettype none

module cache_array #(
	parameter type entry_t = logic,
	parameter int  WORDS   = 1
) (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic [cache_pkg::INDEX_W-1:0] index,
	input  logic [cache_pkg::WORD_W-1:0]  word,
	input  logic                          write,
	input  entry_t                        wdata,
	output entry_t                        rdata
);
	import cache_pkg::*;

	localparam int SEL_W  = (WORDS > 1) ? $clog2(WORDS) : 0;
	localparam int SLOT_W = INDEX_W + SEL_W;
	localparam int DEPTH  = SETS * WORDS;

	entry_t            store [DEPTH];
	logic [SLOT_W-1:0] slot;

	// one entry per set, word select not needed
	if (WORDS == 1) begin : g_set_only
		assign slot = index;
	end else begin : g_set_word
		assign slot = {index, word[SEL_W-1:0]}; // set major, word minor
	end

	assign rdata = store[slot]; // asynchronous read

	// full clear on reset drops every valid bit in one go
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < DEPTH; i++) begin
				store[i] <= '0;
			end
		end else if (write) begin
			store[slot] <= wdata;
		end
	end

endmodule

`default_nettype wire

// File: source/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// address and data widths
	localparam int ADDR_W = 16; // byte address
	localparam int DATA_W = 16;

	// address split: tttt tsss ssss www b
	localparam int TAG_W   = 5;
	localparam int INDEX_W = 7;
	localparam int WORD_W  = 3; // word within line

	localparam int SETS       = 1 << INDEX_W;
	localparam int LINE_WORDS = 1 << WORD_W;

	localparam int MEM_LATENCY = 4; // request to valid data
	localparam int MEM_WORDS   = 1 << (ADDR_W - 1);

	// miss edge through tag write, plus the hit cycle
	localparam int FILL_CYCLES = MEM_LATENCY + 9;

	typedef logic [DATA_W-1:0] word_t;

	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

endpackage

`default_nettype wire
